// File: Makefile
# Verilator build and run of the fire expand testbench

VERILATOR ?= verilator
TOP       ?= tb_fire_expand3
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
SIM_ARGS  ?=

SOURCES := $(shell grep -v '^+' $(FILELIST)) hw/expand_defs.svh
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	-$(SIM_BIN) $(SIM_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TEST FAIL" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi
	@grep -q "TEST PASS" $(LOG) || (echo "Simulation ended early, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: bench/expand_scoreboard.sv
`timescale 1ns/100ps
`include "expand_defs.svh"

module expand_scoreboard (
	input  logic              clk,
	input  logic              rst_gen,
	input  logic              fire2_en_i,
	input  logic              fire3_en_i,
	input  expand_pkg::data_t fire2_ifm_i,
	input  expand_pkg::data_t fire3_ifm_i,
	input  logic              fire2_ram_ack_i,
	input  logic              fire3_ram_ack_i,
	input  expand_pkg::ofm_s  ofm_i,
	input  logic              sample_i,
	input  logic              fire2_finish_i,
	input  logic              fire3_finish_i,
	output int                err_cnt_o,
	output int                sample_cnt_o
);

	localparam int LAYER_TAPS = `EXP_TAPS * `EXP_PIXELS;
	localparam int QDEPTH = 2 * `EXP_PIXELS;

	expand_pkg::data_t taps [`EXP_TAPS];
	expand_pkg::ofm_s  exp_ofm [QDEPTH];
	expand_pkg::ofm_s  head_ofm;
	expand_pkg::data_t cur_pix;
	int exp_layer [QDEPTH];
	int tap_cnt [2];
	int smp_cnt [2];
	int wr_ptr;
	int rd_ptr;
	int cur_layer;
	int err_cnt = 0;
	logic [1:0] tap_ok;
	logic [1:0] acked;
	logic [1:0] exp_finish;
	logic [3:0] last_pipe;
	logic last_tap;

	function automatic int kern_ref(input int layer, input int lane, input int tap);
		return ((3 * tap + 5 * lane + 7 * layer) % 9) - 4;
	endfunction

	function automatic int bias_ref(input int layer, input int lane);
		if (layer == 0) begin
			return (lane + 1) << 12;
		end
		return -((lane + 1) * 3) << 12;
	endfunction

	// Expected lanes for the pixel closed by pix_last
	function automatic expand_pkg::ofm_s pixel_ref(input int layer,
			input expand_pkg::data_t pix_last);
		expand_pkg::ofm_s r;
		int sum;
		int p;
		for (int n = 0; n < `EXP_LANES; n++) begin
			sum = bias_ref(layer, n);
			for (int t = 0; t < `EXP_TAPS; t++) begin
				p = (t == `EXP_TAPS - 1) ? int'($signed(pix_last)) : int'($signed(taps[t]));
				sum += p * kern_ref(layer, n, t);
			end
			r.lane[n] = (sum < 0) ? '0 : expand_pkg::data_t'((sum >> 14) & 32'h7fff);
		end
		return r;
	endfunction

	// Taps past a layer's last pixel are dropped
	assign tap_ok[0] = fire2_en_i && (tap_cnt[0] < LAYER_TAPS);
	assign tap_ok[1] = fire3_en_i && (tap_cnt[1] < LAYER_TAPS);
	assign cur_layer = fire3_en_i ? 1 : 0;
	assign cur_pix = fire3_en_i ? fire3_ifm_i : fire2_ifm_i;
	assign last_tap = tap_ok[cur_layer] && (tap_cnt[cur_layer] % `EXP_TAPS == `EXP_TAPS - 1);
	assign head_ofm = exp_ofm[rd_ptr % QDEPTH];
	assign exp_finish[0] = (smp_cnt[0] == `EXP_PIXELS) && !acked[0];
	assign exp_finish[1] = (smp_cnt[1] == `EXP_PIXELS) && !acked[1];
	assign err_cnt_o = err_cnt;
	assign sample_cnt_o = rd_ptr;

	always_ff @(posedge clk) begin
		if (rst_gen) begin
			tap_cnt[0] <= 0;
			tap_cnt[1] <= 0;
			smp_cnt[0] <= 0;
			smp_cnt[1] <= 0;
			wr_ptr <= 0;
			rd_ptr <= 0;
			acked <= '0;
			last_pipe <= '0;
		end else begin
			last_pipe <= {last_pipe[2:0], last_tap};
			if (tap_ok[cur_layer]) begin
				tap_cnt[cur_layer] <= tap_cnt[cur_layer] + 1;
				taps[tap_cnt[cur_layer] % `EXP_TAPS] <= cur_pix;
				if (last_tap) begin
					exp_ofm[wr_ptr % QDEPTH] <= pixel_ref(cur_layer, cur_pix);
					exp_layer[wr_ptr % QDEPTH] <= cur_layer;
					wr_ptr <= wr_ptr + 1;
				end
			end
			if (sample_i && (rd_ptr < wr_ptr)) begin
				smp_cnt[exp_layer[rd_ptr % QDEPTH]] <= smp_cnt[exp_layer[rd_ptr % QDEPTH]] + 1;
				rd_ptr <= rd_ptr + 1;
			end
			if (fire2_ram_ack_i && (smp_cnt[0] == `EXP_PIXELS)) begin
				acked[0] <= 1'b1;
			end
			if (fire3_ram_ack_i && (smp_cnt[1] == `EXP_PIXELS)) begin
				acked[1] <= 1'b1;
			end
		end
	end

	//////////////////////////////////////////////////
	// Checks
	//////////////////////////////////////////////////

	// Four stages from the last tap to the sample
	a_sample_time: assert property (@(posedge clk) disable iff (rst_gen)
		sample_i == last_pipe[3])
		else begin
			err_cnt++;
			$display("** Error sample_time: expected %b, actual %b",
				$sampled(last_pipe[3]), $sampled(sample_i));
		end

	a_fire2_finish: assert property (@(posedge clk) disable iff (rst_gen)
		fire2_finish_i == exp_finish[0])
		else begin
			err_cnt++;
			$display("** Error fire2_finish: expected %b, actual %b",
				$sampled(exp_finish[0]), $sampled(fire2_finish_i));
		end

	a_fire3_finish: assert property (@(posedge clk) disable iff (rst_gen)
		fire3_finish_i == exp_finish[1])
		else begin
			err_cnt++;
			$display("** Error fire3_finish: expected %b, actual %b",
				$sampled(exp_finish[1]), $sampled(fire3_finish_i));
		end

	for (genvar n = 0; n < `EXP_LANES; n++) begin : g_lane
		a_ofm_lane: assert property (@(posedge clk) disable iff (rst_gen)
			sample_i |-> (ofm_i.lane[n] == head_ofm.lane[n]))
			else begin
				err_cnt++;
				$display("** Error ofm_lane%0d: expected %h, actual %h", n,
					$sampled(head_ofm.lane[n]), $sampled(ofm_i.lane[n]));
			end
	end

endmodule

// File: bench/tb_fire_expand3.sv
`timescale 1ns/100ps
`include "expand_defs.svh"

module tb_fire_expand3;

	localparam int LAYER_TAPS = `EXP_TAPS * `EXP_PIXELS;
	localparam int STREAM_LIMIT = 3 * LAYER_TAPS;
	localparam int WAIT_LIMIT = 200;

	logic clk;
	logic rst_gen;
	logic fire2_en;
	logic fire3_en;
	logic fire2_ram_ack;
	logic fire3_ram_ack;
	logic sample;
	logic fire2_finish;
	logic fire3_finish;
	expand_pkg::data_t fire2_ifm;
	expand_pkg::data_t fire3_ifm;
	expand_pkg::ofm_s  ofm;
	int seed;
	int err_cnt;
	int sample_cnt;
	int count_err;
	int timeouts;

	fire_expand3_top i_dut (
		.clk             (clk),
		.rst_gen         (rst_gen),
		.fire2_en_i      (fire2_en),
		.fire3_en_i      (fire3_en),
		.fire2_ifm_i     (fire2_ifm),
		.fire3_ifm_i     (fire3_ifm),
		.fire2_ram_ack_i (fire2_ram_ack),
		.fire3_ram_ack_i (fire3_ram_ack),
		.ofm_o           (ofm),
		.sample_o        (sample),
		.fire2_finish_o  (fire2_finish),
		.fire3_finish_o  (fire3_finish)
	);

	expand_scoreboard u_sb (
		.clk             (clk),
		.rst_gen         (rst_gen),
		.fire2_en_i      (fire2_en),
		.fire3_en_i      (fire3_en),
		.fire2_ifm_i     (fire2_ifm),
		.fire3_ifm_i     (fire3_ifm),
		.fire2_ram_ack_i (fire2_ram_ack),
		.fire3_ram_ack_i (fire3_ram_ack),
		.ofm_i           (ofm),
		.sample_i        (sample),
		.fire2_finish_i  (fire2_finish),
		.fire3_finish_i  (fire3_finish),
		.err_cnt_o       (err_cnt),
		.sample_cnt_o    (sample_cnt)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	task automatic drive_tap(input int layer, input logic en, input expand_pkg::data_t pix);
		if (layer == 0) begin
			fire2_en <= en;
			fire2_ifm <= pix;
		end else begin
			fire3_en <= en;
			fire3_ifm <= pix;
		end
	endtask

	function automatic logic finish_level(input int layer);
		return (layer == 0) ? fire2_finish : fire3_finish;
	endfunction

	//////////////////////////////////////////////////
	// Layer stream with random stalls
	//////////////////////////////////////////////////

	task automatic run_layer(input int layer);
		int sent;
		int cycles;
		logic en;
		sent = 0;
		cycles = 0;
		while ((sent < LAYER_TAPS) && (cycles < STREAM_LIMIT)) begin
			@(posedge clk);
			// Roughly one cycle in four is a stall
			en = ($random(seed) & 3) != 0;
			// Pixels below 2^15 stay positive yet push sums on both sides of zero
			drive_tap(layer, en, expand_pkg::data_t'($random(seed) & 16'h7fff));
			if (en) begin
				sent++;
			end
			cycles++;
		end
		@(posedge clk);
		drive_tap(layer, 1'b0, '0);
		if (sent < LAYER_TAPS) begin
			timeouts++;
			$display("Timeout: fire%0d stream sent only %0d of %0d taps", layer + 2, sent,
				LAYER_TAPS);
		end
	endtask

	// A finished layer must ignore these
	task automatic feed_after_finish(input int layer, input int n);
		for (int i = 0; i < n; i++) begin
			@(posedge clk);
			drive_tap(layer, 1'b1, expand_pkg::data_t'($random(seed) & 8'hff));
		end
		@(posedge clk);
		drive_tap(layer, 1'b0, '0);
		repeat (8) @(posedge clk);
	endtask

	task automatic wait_finish(input int layer, input logic level);
		int cycles;
		cycles = 0;
		while ((finish_level(layer) != level) && (cycles < WAIT_LIMIT)) begin
			@(posedge clk);
			cycles++;
		end
		if (finish_level(layer) != level) begin
			timeouts++;
			$display("Timeout: fire%0d finish did not go to %b within %0d cycles", layer + 2,
				level, WAIT_LIMIT);
		end
	endtask

	task automatic send_ack(input int layer);
		@(posedge clk);
		if (layer == 0) begin
			fire2_ram_ack <= 1'b1;
		end else begin
			fire3_ram_ack <= 1'b1;
		end
		@(posedge clk);
		fire2_ram_ack <= 1'b0;
		fire3_ram_ack <= 1'b0;
	endtask

	initial begin
		seed = 32'hbd2e548b;
		count_err = 0;
		timeouts = 0;
		rst_gen = 1'b1;
		fire2_en = 1'b0;
		fire3_en = 1'b0;
		fire2_ifm = '0;
		fire3_ifm = '0;
		fire2_ram_ack = 1'b0;
		fire3_ram_ack = 1'b0;
		repeat (16) @(posedge clk);
		rst_gen <= 1'b0;

		// Fire2 runs before fire3
		for (int layer = 0; layer < 2; layer++) begin
			run_layer(layer);
			wait_finish(layer, 1'b1);
			feed_after_finish(layer, 2 * `EXP_TAPS);
			// The other layer's ack leaves this finish level alone
			send_ack(1 - layer);
			send_ack(layer);
			wait_finish(layer, 1'b0);
		end
		repeat (8) @(posedge clk);

		if (sample_cnt != 2 * `EXP_PIXELS) begin
			count_err++;
			$display("** Error sample_count: expected %0d, actual %0d", 2 * `EXP_PIXELS,
				sample_cnt);
		end
		$display("Samples %0d, assertion errors %0d, count errors %0d, timeouts %0d",
			sample_cnt, err_cnt, count_err, timeouts);
		if ((err_cnt == 0) && (count_err == 0) && (timeouts == 0)) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

// File: hw/expand_defs.svh
`ifndef EXPAND_DEFS_SVH
`define EXPAND_DEFS_SVH

//////////////////////////////////////////////////
// Engine geometry
//////////////////////////////////////////////////

// Output channels computed in parallel
`define EXP_LANES  8
// Input channels per tap window
`define EXP_CHIN   4
`define EXP_WIN    3
// Taps per output pixel, channel then window order
`define EXP_TAPS   (`EXP_WIN * `EXP_WIN * `EXP_CHIN)
`define EXP_WOUT   4
`define EXP_PIXELS (`EXP_WOUT * `EXP_WOUT)

//////////////////////////////////////////////////
// Data widths
//////////////////////////////////////////////////

// Feature, kernel and result words
`define EXP_DW 16
// Accumulator and bias
`define EXP_AW 32

`endif

// File: hw/expand_mac_array.sv
`timescale 1ns/100ps
`include "expand_defs.svh"

module expand_mac_array (
	input  logic                 clk,
	input  logic                 rst_gen,
	input  expand_pkg::tap_s     tap_i,
	input  expand_pkg::kern_s    kern_i,
	output expand_pkg::acc_vec_s acc_o,
	output logic                 acc_done_o,
	output expand_pkg::layer_e   acc_layer_o
);

	expand_pkg::data_t    pix_d;
	expand_pkg::layer_e   layer_d;
	expand_pkg::layer_e   layer_q;
	expand_pkg::acc_t     prod [`EXP_LANES];
	expand_pkg::acc_vec_s acc_q;
	logic valid_d;
	logic first_d;
	logic last_d;
	logic done_q;

	//////////////////////////////////////////////////
	// Delay stage to meet the ROM read
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (rst_gen) begin
			valid_d <= 1'b0;
			first_d <= 1'b0;
			last_d <= 1'b0;
			layer_d <= expand_pkg::LAYER_FIRE2;
		end else begin
			valid_d <= tap_i.valid;
			first_d <= tap_i.first;
			last_d <= tap_i.last;
			layer_d <= tap_i.layer;
		end
	end

	always_ff @(posedge clk) begin
		pix_d <= tap_i.pix;
	end

	// Signed 16x16 products, sign extended into the accumulator width
	always_comb begin
		for (int n = 0; n < `EXP_LANES; n++) begin
			prod[n] = $signed(pix_d) * $signed(kern_i.lane[n]);
		end
	end

	// First tap loads instead of adding, no bubble between pixels
	always_ff @(posedge clk) begin
		for (int n = 0; n < `EXP_LANES; n++) begin
			if (valid_d && first_d) begin
				acc_q.lane[n] <= prod[n];
			end else if (valid_d) begin
				acc_q.lane[n] <= acc_q.lane[n] + prod[n];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst_gen) begin
			done_q <= 1'b0;
			layer_q <= expand_pkg::LAYER_FIRE2;
		end else begin
			done_q <= valid_d && last_d;
			layer_q <= layer_d;
		end
	end

	assign acc_o = acc_q;
	assign acc_done_o = done_q;
	assign acc_layer_o = layer_q;

	a_first_valid: assert property (@(posedge clk) disable iff (rst_gen)
		tap_i.first |-> tap_i.valid)
		else $error("first tap without valid");

endmodule

// File: hw/expand_output_stage.sv
`timescale 1ns/100ps
`include "expand_defs.svh"

module expand_output_stage (
	input  logic                 clk,
	input  logic                 rst_gen,
	input  expand_pkg::acc_vec_s acc_i,
	input  logic                 acc_done_i,
	input  expand_pkg::layer_e   acc_layer_i,
	input  expand_pkg::bias_s    bias_i,
	input  logic                 fire2_ram_ack_i,
	input  logic                 fire3_ram_ack_i,
	output expand_pkg::ofm_s     ofm_o,
	output logic                 sample_o,
	output logic [1:0]           layer_done_o,
	output logic                 fire2_finish_o,
	output logic                 fire3_finish_o
);

	expand_pkg::acc_t     sum [`EXP_LANES];
	expand_pkg::ofm_s     res;
	expand_pkg::ofm_s     ofm_q;
	expand_pkg::pix_cnt_t pix_cnt_q [2];
	logic [1:0] ack;
	logic [1:0] done_q;
	logic [1:0] ack_seen_q;
	logic [1:0] finish_q;
	logic sample_q;
	logic take;

	assign ack = {fire3_ram_ack_i, fire2_ram_ack_i};

	// A pixel of a finished layer is dropped
	assign take = acc_done_i && !done_q[acc_layer_i];

	//////////////////////////////////////////////////
	// Bias, ReLU and fixed-point slice
	//////////////////////////////////////////////////

	always_comb begin
		for (int n = 0; n < `EXP_LANES; n++) begin
			sum[n] = acc_i.lane[n] + bias_i.lane[n];
			if (sum[n][`EXP_AW-1]) begin
				res.lane[n] = '0;
			end else begin
				// Q14 result keeps 15 magnitude bits
				res.lane[n] = {1'b0, sum[n][28:14]};
			end
		end
	end

	// Holds until the next sample
	always_ff @(posedge clk) begin
		if (take) begin
			ofm_q <= res;
		end
	end

	//////////////////////////////////////////////////
	// Pixel counts and finish levels
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (rst_gen) begin
			sample_q <= 1'b0;
			done_q <= '0;
			ack_seen_q <= '0;
			finish_q <= '0;
			for (int l = 0; l < 2; l++) begin
				pix_cnt_q[l] <= '0;
			end
		end else begin
			sample_q <= take;
			for (int l = 0; l < 2; l++) begin
				if (take && (int'(acc_layer_i) == l)) begin
					pix_cnt_q[l] <= pix_cnt_q[l] + 1'b1;
					if (pix_cnt_q[l] == `EXP_PIXELS - 1) begin
						done_q[l] <= 1'b1;
					end
				end
				// Ack only counts once the layer is done
				if (done_q[l] && ack[l]) begin
					ack_seen_q[l] <= 1'b1;
				end
				finish_q[l] <= done_q[l] && !ack_seen_q[l] && !ack[l];
			end
		end
	end

	assign ofm_o = ofm_q;
	assign sample_o = sample_q;
	assign layer_done_o = done_q;
	assign fire2_finish_o = finish_q[0];
	assign fire3_finish_o = finish_q[1];

	// No finished pixel of a done layer reaches the sample path
	a_no_late_sample: assert property (@(posedge clk) disable iff (rst_gen)
		acc_done_i |-> !done_q[acc_layer_i])
		else $error("pixel for a layer already done");

endmodule

// File: hw/expand_pkg.sv
`include "expand_defs.svh"

package expand_pkg;

	typedef logic [`EXP_DW-1:0] data_t;
	typedef logic [`EXP_AW-1:0] acc_t;
	typedef logic [$clog2(`EXP_TAPS)-1:0] tap_addr_t;
	// One spare bit so the last count is reachable
	typedef logic [$clog2(`EXP_PIXELS):0] pix_cnt_t;

	typedef enum logic {
		LAYER_FIRE2 = 1'b0,
		LAYER_FIRE3 = 1'b1
	} layer_e;

	typedef enum logic [1:0] {
		SEQ_IDLE = 2'd0,
		SEQ_RUN  = 2'd1,
		SEQ_HOLD = 2'd2
	} seq_state_e;

	// Sequencer to MAC array
	typedef struct packed {
		data_t  pix;
		logic   first;
		logic   last;
		logic   valid;
		layer_e layer;
	} tap_s;

	typedef struct packed {data_t [`EXP_LANES-1:0] lane;} kern_s;
	typedef struct packed {acc_t [`EXP_LANES-1:0] lane;} bias_s;
	typedef struct packed {acc_t [`EXP_LANES-1:0] lane;} acc_vec_s;
	typedef struct packed {data_t [`EXP_LANES-1:0] lane;} ofm_s;

endpackage

// File: hw/expand_tap_sequencer.sv
`timescale 1ns/100ps
`include "expand_defs.svh"

module expand_tap_sequencer (
	input  logic                  clk,
	input  logic                  rst_gen,
	input  logic                  fire2_en_i,
	input  logic                  fire3_en_i,
	input  expand_pkg::data_t     fire2_ifm_i,
	input  expand_pkg::data_t     fire3_ifm_i,
	input  logic [1:0]            layer_done_i,
	output expand_pkg::tap_s      tap_o,
	output expand_pkg::tap_addr_t rom_addr_o,
	output expand_pkg::layer_e    rom_layer_o
);

	expand_pkg::seq_state_e state_q;
	expand_pkg::seq_state_e state_d;
	expand_pkg::tap_addr_t  tap_cnt_q;
	expand_pkg::tap_addr_t  tap_cnt_d;
	expand_pkg::tap_addr_t  addr_q;
	expand_pkg::layer_e     layer_q;
	expand_pkg::layer_e     go_layer;
	expand_pkg::data_t      go_pix;
	expand_pkg::data_t      pix_q;
	logic f2_ok;
	logic f3_ok;
	logic go;
	logic abort;
	logic first_q;
	logic last_q;
	logic valid_q;

	// Finished layers no longer count as enabled
	assign f2_ok = fire2_en_i && !layer_done_i[0];
	assign f3_ok = fire3_en_i && !layer_done_i[1];

	always_comb begin
		// Layer is only chosen between pixels
		if (state_q == expand_pkg::SEQ_IDLE) begin
			go = f2_ok || f3_ok;
			go_layer = f3_ok ? expand_pkg::LAYER_FIRE3 : expand_pkg::LAYER_FIRE2;
		end else begin
			go_layer = layer_q;
			go = (layer_q == expand_pkg::LAYER_FIRE3) ? f3_ok : f2_ok;
		end
		go_pix = (go_layer == expand_pkg::LAYER_FIRE3) ? fire3_ifm_i : fire2_ifm_i;
	end

	// Partial pixel left behind when the layer completes
	assign abort = layer_done_i[layer_q] && (state_q != expand_pkg::SEQ_IDLE);

	always_comb begin
		state_d = state_q;
		tap_cnt_d = tap_cnt_q;
		if (abort) begin
			state_d = expand_pkg::SEQ_IDLE;
			tap_cnt_d = '0;
		end else if (go) begin
			state_d = expand_pkg::SEQ_RUN;
			tap_cnt_d = (tap_cnt_q == `EXP_TAPS - 1) ? '0 : tap_cnt_q + 1'b1;
		end else if (state_q != expand_pkg::SEQ_IDLE) begin
			// Stall mid-pixel keeps the layer locked
			state_d = (tap_cnt_q == '0) ? expand_pkg::SEQ_IDLE : expand_pkg::SEQ_HOLD;
		end
	end

	always_ff @(posedge clk) begin
		if (rst_gen) begin
			state_q <= expand_pkg::SEQ_IDLE;
			tap_cnt_q <= '0;
			addr_q <= '0;
			layer_q <= expand_pkg::LAYER_FIRE2;
			valid_q <= 1'b0;
			first_q <= 1'b0;
			last_q <= 1'b0;
		end else begin
			state_q <= state_d;
			tap_cnt_q <= tap_cnt_d;
			addr_q <= tap_cnt_q;
			valid_q <= go;
			first_q <= go && (tap_cnt_q == '0);
			last_q <= go && (tap_cnt_q == `EXP_TAPS - 1);
			if (go) begin
				layer_q <= go_layer;
			end
		end
	end

	always_ff @(posedge clk) begin
		pix_q <= go_pix;
	end

	assign tap_o = expand_pkg::tap_s'{pix: pix_q, first: first_q, last: last_q,
		valid: valid_q, layer: layer_q};
	assign rom_addr_o = addr_q;
	assign rom_layer_o = layer_q;

	a_one_enable: assert property (@(posedge clk) disable iff (rst_gen)
		!(fire2_en_i && fire3_en_i))
		else $error("fire2 and fire3 enables high together");

endmodule

// File: hw/expand_weight_rom.sv
`timescale 1ns/100ps
`include "expand_defs.svh"

module expand_weight_rom (
	input  logic                  clk,
	input  expand_pkg::tap_addr_t addr_i,
	input  expand_pkg::layer_e    layer_i,
	output expand_pkg::kern_s     kern_o,
	output expand_pkg::bias_s     bias_o
);

	expand_pkg::data_t kern_tbl [2][`EXP_TAPS][`EXP_LANES];
	expand_pkg::acc_t  bias_tbl [2][`EXP_LANES];
	expand_pkg::kern_s kern_q;
	expand_pkg::bias_s bias_q;

	// Small signed kernels in -4..4, layer 0 is fire2
	function automatic expand_pkg::data_t kern_rule(input int layer, input int lane,
			input int tap);
		int v;
		v = ((3 * tap + 5 * lane + 7 * layer) % 9) - 4;
		return expand_pkg::data_t'(v);
	endfunction

	// Fire3 biases are negative, so ReLU zeroes some lanes
	function automatic expand_pkg::acc_t bias_rule(input int layer, input int lane);
		int v;
		v = (layer == 0) ? (lane + 1) * 4096 : -(lane + 1) * 3 * 4096;
		return expand_pkg::acc_t'(v);
	endfunction

	for (genvar ly = 0; ly < 2; ly++) begin : g_layer
		for (genvar ln = 0; ln < `EXP_LANES; ln++) begin : g_lane
			assign bias_tbl[ly][ln] = bias_rule(ly, ln);
			for (genvar t = 0; t < `EXP_TAPS; t++) begin : g_tap
				assign kern_tbl[ly][t][ln] = kern_rule(ly, ln, t);
			end
		end
	end

	// Registered read, bias picked up at address 0
	always_ff @(posedge clk) begin
		for (int n = 0; n < `EXP_LANES; n++) begin
			kern_q.lane[n] <= kern_tbl[layer_i][addr_i][n];
			if (addr_i == '0) begin
				bias_q.lane[n] <= bias_tbl[layer_i][n];
			end
		end
	end

	assign kern_o = kern_q;
	assign bias_o = bias_q;

endmodule

// File: hw/fire_expand3_top.sv
`timescale 1ns/100ps

module fire_expand3_top (
	input  logic              clk,
	input  logic              rst_gen,
	input  logic              fire2_en_i,
	input  logic              fire3_en_i,
	input  expand_pkg::data_t fire2_ifm_i,
	input  expand_pkg::data_t fire3_ifm_i,
	input  logic              fire2_ram_ack_i,
	input  logic              fire3_ram_ack_i,
	output expand_pkg::ofm_s  ofm_o,
	output logic              sample_o,
	output logic              fire2_finish_o,
	output logic              fire3_finish_o
);

	expand_pkg::tap_s      tap;
	expand_pkg::tap_addr_t rom_addr;
	expand_pkg::layer_e    rom_layer;
	expand_pkg::kern_s     kern;
	expand_pkg::bias_s     bias;
	expand_pkg::acc_vec_s  acc;
	expand_pkg::layer_e    acc_layer;
	logic                  acc_done;
	logic [1:0]            layer_done;

	// Decode
	expand_tap_sequencer u_seq (
		.clk          (clk),
		.rst_gen      (rst_gen),
		.fire2_en_i   (fire2_en_i),
		.fire3_en_i   (fire3_en_i),
		.fire2_ifm_i  (fire2_ifm_i),
		.fire3_ifm_i  (fire3_ifm_i),
		.layer_done_i (layer_done),
		.tap_o        (tap),
		.rom_addr_o   (rom_addr),
		.rom_layer_o  (rom_layer)
	);

	expand_weight_rom u_rom (
		.clk     (clk),
		.addr_i  (rom_addr),
		.layer_i (rom_layer),
		.kern_o  (kern),
		.bias_o  (bias)
	);

	// Execute
	expand_mac_array u_mac (
		.clk         (clk),
		.rst_gen     (rst_gen),
		.tap_i       (tap),
		.kern_i      (kern),
		.acc_o       (acc),
		.acc_done_o  (acc_done),
		.acc_layer_o (acc_layer)
	);

	// Results and layer bookkeeping
	expand_output_stage u_out (
		.clk             (clk),
		.rst_gen         (rst_gen),
		.acc_i           (acc),
		.acc_done_i      (acc_done),
		.acc_layer_i     (acc_layer),
		.bias_i          (bias),
		.fire2_ram_ack_i (fire2_ram_ack_i),
		.fire3_ram_ack_i (fire3_ram_ack_i),
		.ofm_o           (ofm_o),
		.sample_o        (sample_o),
		.layer_done_o    (layer_done),
		.fire2_finish_o  (fire2_finish_o),
		.fire3_finish_o  (fire3_finish_o)
	);

endmodule

// File: vlog.f
+incdir+hw
hw/expand_pkg.sv
hw/expand_weight_rom.sv
hw/expand_tap_sequencer.sv
hw/expand_mac_array.sv
hw/expand_output_stage.sv
hw/fire_expand3_top.sv
bench/expand_scoreboard.sv
bench/tb_fire_expand3.sv
